// File: vlog.f
+incdir+sim
logic/amo_pkg.sv
logic/a_decoder.sv
logic/instr_fetch.sv
logic/instr_queue.sv
logic/decode_stage.sv
logic/amo_decode_top.sv
sim/tb_amo_decode.sv

// File: sim/tb_amo_model.svh
/*
 * Reference model for the AMO decode front testbench
 * Expected control fields from the RV32A decode rules, plus encoders
 * that build instruction words from their fields
 */

`ifndef TB_AMO_MODEL_SVH
`define TB_AMO_MODEL_SVH

// Control fields as the decode stage should present them
typedef struct packed {
  logic       lsu_en;
  logic       lsu_we;
  logic       lsu_sext;
  logic [1:0] lsu_size;
  logic [5:0] lsu_atop;
  logic       rf_we;
  logic [1:0] rf_re;
  logic [1:0] op_a_sel;
  logic [1:0] op_c_sel;
  logic       illegal;
} ctrl_t;

// R-type layout used by every atomic
function automatic logic [31:0] build_word(input logic [6:0] opcode, input logic [2:0] funct3,
                                           input logic [4:0] funct5, input logic [4:0] rd,
                                           input logic [4:0] rs1, input logic [4:0] rs2,
                                           input logic aq, input logic rl);
  return {funct5, aq, rl, rs2, rs1, funct3, rd, opcode};
endfunction

// The eleven RV32A codes by index
function automatic logic [4:0] funct5_at(input int idx);
  case (idx)
    0:       return AMO_LR;
    1:       return AMO_SC;
    2:       return AMO_SWAP;
    3:       return AMO_ADD;
    4:       return AMO_XOR;
    5:       return AMO_AND;
    6:       return AMO_OR;
    7:       return AMO_MIN;
    8:       return AMO_MAX;
    9:       return AMO_MINU;
    default: return AMO_MAXU;
  endcase
endfunction

function automatic logic is_known_funct5(input logic [4:0] f5);
  logic hit;
  hit = 1'b0;
  for (int i = 0; i < 11; i++) begin
    if (funct5_at(i) == f5) hit = 1'b1;
  end
  return hit;
endfunction

// Expected fields for one word
function automatic ctrl_t expected_ctrl(input logic [31:0] instr);
  ctrl_t c;
  c          = '0;
  c.lsu_size = LSU_SIZE_WORD;
  c.op_a_sel = OP_A_NONE;
  c.op_c_sel = OP_C_NONE;
  c.illegal  = 1'b1;
  // Anything but a word atomic with a known code stays illegal
  if (instr[6:0] != OPCODE_AMO || instr[14:12] != AMO_FUNCT3_W) return c;
  if (!is_known_funct5(instr[31:27])) return c;
  // LR has no rs2 operand
  if (instr[31:27] == AMO_LR && instr[24:20] != 5'd0) return c;
  c.illegal  = 1'b0;
  c.lsu_en   = 1'b1;
  c.lsu_sext = 1'b1;
  c.rf_we    = 1'b1;
  c.rf_re    = 2'b01;
  c.op_a_sel = OP_A_REGA_OR_FWD;
  c.lsu_atop = {1'b1, instr[31:27]};
  if (instr[31:27] != AMO_LR) begin
    c.lsu_we   = 1'b1;
    c.rf_re    = 2'b11;
    c.op_c_sel = OP_C_REGB_OR_FWD;
  end
  return c;
endfunction

`endif

// File: sim/tb_amo_decode.sv
/*
 * Testbench for the AMO decode front
 * Drives the fetch port and stall, keeps a scoreboard of accepted words
 * and checks decoded fields, stall hold, reset state and back-pressure
 */

module tb_amo_decode import amo_pkg::*; ();

  `include "tb_amo_model.svh"

  localparam int CLK_PERIOD     = 4;
  // Words per test for the watchdog budget
  localparam int T1_WORDS       = 2;
  localparam int T2_WORDS       = 5;
  localparam int T3_WORDS       = 22;
  localparam int T4_WORDS       = 8;
  localparam int T5_WORDS       = 7;
  localparam int T6_WORDS       = 300;
  localparam int TOTAL_WORDS    = T1_WORDS + T2_WORDS + T3_WORDS + T4_WORDS + T5_WORDS +
                                  T6_WORDS;
  localparam int TIMEOUT_CYCLES = TOTAL_WORDS * 20 + 100;

  logic            clk;
  logic            rst_n_i;
  logic            fetch_valid_i;
  logic [31:0]     fetch_instr_i;
  logic            fetch_ready_o;
  logic            stall_i;
  logic            id_valid_o;
  logic [31:0]     id_pc_o;
  logic            id_lsu_en_o;
  logic            id_lsu_we_o;
  logic            id_lsu_sext_o;
  logic [1:0]      id_lsu_size_o;
  logic [5:0]      id_lsu_atop_o;
  logic            id_rf_we_o;
  logic [1:0]      id_rf_re_o;
  op_a_sel_e       id_op_a_sel_o;
  op_c_sel_e       id_op_c_sel_o;
  logic            id_illegal_o;

  // Scoreboard entries hold the PC in the upper half and the word in the lower half
  logic [63:0]     exp_q [$];
  int              err_cnt;
  int              test_err_base;
  int              tests_passed;
  int              tests_failed;

  // Cycle model of the front
  int              m_inflight;
  logic            m_valid;
  logic [31:0]     m_pc;
  logic            reset_seen;
  logic            hold_prev;
  logic [50:0]     held_out;
  logic            accept;
  logic            load;
  logic            traffic_done;

  amo_decode_top UUT (
    .clk           (clk),
    .rst_n_i       (rst_n_i),
    .fetch_valid_i (fetch_valid_i),
    .fetch_instr_i (fetch_instr_i),
    .fetch_ready_o (fetch_ready_o),
    .stall_i       (stall_i),
    .id_valid_o    (id_valid_o),
    .id_pc_o       (id_pc_o),
    .id_lsu_en_o   (id_lsu_en_o),
    .id_lsu_we_o   (id_lsu_we_o),
    .id_lsu_sext_o (id_lsu_sext_o),
    .id_lsu_size_o (id_lsu_size_o),
    .id_lsu_atop_o (id_lsu_atop_o),
    .id_rf_we_o    (id_rf_we_o),
    .id_rf_re_o    (id_rf_re_o),
    .id_op_a_sel_o (id_op_a_sel_o),
    .id_op_c_sel_o (id_op_c_sel_o),
    .id_illegal_o  (id_illegal_o)
  );

  initial clk = 1'b0;
  always #(CLK_PERIOD / 2) clk = ~clk;

  ////////////////////////////////////////////////////////////////////////////
  // Helpers
  ////////////////////////////////////////////////////////////////////////////

  // Advance one cycle and land just after the rising edge
  task automatic step();
    @(posedge clk);
    #1;
  endtask

  task automatic report_mismatch(input string name, input logic [63:0] exp,
                                 input logic [63:0] act);
    $display("Mismatch at time %0t: %s expected 0x%0h, actual 0x%0h", $time, name, exp, act);
    err_cnt++;
  endtask

  task automatic report_error(input string msg);
    $display("Error at time %0t: %s", $time, msg);
    err_cnt++;
  endtask

  // Everything the stage must hold while stalled
  function automatic logic [50:0] output_snapshot();
    return {id_pc_o, id_lsu_en_o, id_lsu_we_o, id_lsu_sext_o, id_lsu_size_o, id_lsu_atop_o,
            id_rf_we_o, id_rf_re_o, id_op_a_sel_o, id_op_c_sel_o, id_illegal_o};
  endfunction

  task automatic check_head(input logic [63:0] entry);
    ctrl_t exp;
    exp = expected_ctrl(entry[31:0]);
    assert (id_pc_o === entry[63:32]) else report_mismatch("id_pc_o", entry[63:32], id_pc_o);
    assert (id_lsu_en_o === exp.lsu_en)
      else report_mismatch("id_lsu_en_o", exp.lsu_en, id_lsu_en_o);
    assert (id_lsu_we_o === exp.lsu_we)
      else report_mismatch("id_lsu_we_o", exp.lsu_we, id_lsu_we_o);
    assert (id_lsu_sext_o === exp.lsu_sext)
      else report_mismatch("id_lsu_sext_o", exp.lsu_sext, id_lsu_sext_o);
    assert (id_lsu_size_o === exp.lsu_size)
      else report_mismatch("id_lsu_size_o", exp.lsu_size, id_lsu_size_o);
    assert (id_lsu_atop_o === exp.lsu_atop)
      else report_mismatch("id_lsu_atop_o", exp.lsu_atop, id_lsu_atop_o);
    assert (id_rf_we_o === exp.rf_we) else report_mismatch("id_rf_we_o", exp.rf_we, id_rf_we_o);
    assert (id_rf_re_o === exp.rf_re) else report_mismatch("id_rf_re_o", exp.rf_re, id_rf_re_o);
    assert (id_op_a_sel_o === exp.op_a_sel)
      else report_mismatch("id_op_a_sel_o", exp.op_a_sel, id_op_a_sel_o);
    assert (id_op_c_sel_o === exp.op_c_sel)
      else report_mismatch("id_op_c_sel_o", exp.op_c_sel, id_op_c_sel_o);
    assert (id_illegal_o === exp.illegal)
      else report_mismatch("id_illegal_o", exp.illegal, id_illegal_o);
  endtask

  // Hold the strobe until the queue takes the word
  task automatic drive_word(input logic [31:0] instr, input int gap);
    fetch_valid_i = 1'b0;
    repeat (gap) step();
    fetch_valid_i = 1'b1;
    fetch_instr_i = instr;
    // Ready only moves at edges and so predicts the coming edge
    while (!fetch_ready_o) step();
    step();
    fetch_valid_i = 1'b0;
  endtask

  task automatic wait_drain();
    while (exp_q.size() != 0) step();
  endtask

  task automatic start_test();
    test_err_base = err_cnt;
  endtask

  task automatic finish_test(input string name);
    if (err_cnt == test_err_base) begin
      tests_passed++;
      $display("Test %s passed", name);
    end else begin
      tests_failed++;
      $display("Test %s failed with %0d errors", name, err_cnt - test_err_base);
    end
  endtask

  // Mix of legal atomics and the illegal kinds
  function automatic logic [31:0] random_word();
    int         kind;
    logic [4:0] f5;
    logic [4:0] rs2;
    logic [2:0] f3;
    logic [6:0] op;
    kind = int'($urandom % 10);
    f5   = funct5_at(int'($urandom % 11));
    rs2  = 5'($urandom);
    f3   = AMO_FUNCT3_W;
    op   = OPCODE_AMO;
    if (kind < 7) begin
      if (f5 == AMO_LR) rs2 = 5'd0;
    end else if (kind == 7) begin
      f5  = AMO_LR;
      rs2 = 5'($urandom_range(31, 1));
    end else if (kind == 8) begin
      do f5 = 5'($urandom); while (is_known_funct5(f5));
    end else if ($urandom % 2) begin
      f3 = 3'($urandom);
      if (f3 == AMO_FUNCT3_W) f3 = 3'b011;
    end else begin
      op = 7'($urandom);
      if (op == OPCODE_AMO) op = 7'h33;
    end
    return build_word(op, f3, f5, 5'($urandom), 5'($urandom), rs2, 1'($urandom), 1'($urandom));
  endfunction

  ////////////////////////////////////////////////////////////////////////////
  // Checker sampling at the edge before any register update
  ////////////////////////////////////////////////////////////////////////////

  always @(posedge clk) begin
    if (!rst_n_i) begin
      m_inflight = 0;
      m_valid    = 1'b0;
      m_pc       = BOOT_ADDR;
      reset_seen = 1'b1;
      hold_prev  = 1'b0;
      exp_q.delete();
    end else begin
      // First edge after reset still shows the reset state
      if (reset_seen) begin
        assert (id_valid_o === 1'b0) else report_mismatch("id_valid_o", 0, id_valid_o);
        assert (fetch_ready_o === 1'b1) else report_mismatch("fetch_ready_o", 1, fetch_ready_o);
        reset_seen = 1'b0;
      end
      // Ready drops exactly when four words wait behind the stage
      assert (fetch_ready_o === (m_inflight != QUEUE_DEPTH))
        else report_mismatch("fetch_ready_o", m_inflight != QUEUE_DEPTH, fetch_ready_o);
      assert (id_valid_o === m_valid) else report_mismatch("id_valid_o", m_valid, id_valid_o);
      if (hold_prev) begin
        assert (output_snapshot() === held_out)
          else report_mismatch("id outputs under stall", held_out, output_snapshot());
      end
      // Consumed entry must be the oldest accepted word
      if (id_valid_o && !stall_i) begin
        if (exp_q.size() == 0) begin
          report_error("decode stage delivered a word that was never fetched");
        end else begin
          check_head(exp_q[0]);
          void'(exp_q.pop_front());
        end
      end
      accept = fetch_valid_i && fetch_ready_o;
      if (accept) begin
        exp_q.push_back({m_pc, fetch_instr_i});
        m_pc = m_pc + 32'd4;
      end
      load = (m_inflight > 0) && (!m_valid || !stall_i);
      if (load) begin
        m_valid = 1'b1;
      end else if (!stall_i) begin
        m_valid = 1'b0;
      end
      m_inflight = m_inflight + int'(accept) - int'(load);
      hold_prev  = id_valid_o && stall_i;
      held_out   = output_snapshot();
    end
  end

  ////////////////////////////////////////////////////////////////////////////
  // Stimulus
  ////////////////////////////////////////////////////////////////////////////

  initial begin
    logic [4:0] f5;
    logic [4:0] rs2;
    void'($urandom(32'h20cc));
    err_cnt       = 0;
    tests_passed  = 0;
    tests_failed  = 0;
    traffic_done  = 1'b0;
    rst_n_i       = 1'b0;
    fetch_valid_i = 1'b0;
    fetch_instr_i = '0;
    stall_i       = 1'b0;
    repeat (3) @(posedge clk);
    #1;
    rst_n_i = 1'b1;

    // Reset state and the boot PC
    start_test();
    assert (id_valid_o === 1'b0) else report_mismatch("id_valid_o", 0, id_valid_o);
    assert (fetch_ready_o === 1'b1) else report_mismatch("fetch_ready_o", 1, fetch_ready_o);
    drive_word(build_word(OPCODE_AMO, AMO_FUNCT3_W, AMO_ADD, 5'd1, 5'd2, 5'd3, 1'b0, 1'b0), 0);
    step();
    assert (id_valid_o === 1'b1) else report_mismatch("id_valid_o", 1, id_valid_o);
    assert (id_pc_o === BOOT_ADDR) else report_mismatch("id_pc_o", BOOT_ADDR, id_pc_o);
    drive_word(build_word(OPCODE_AMO, AMO_FUNCT3_W, AMO_LR, 5'd4, 5'd5, 5'd0, 1'b1, 1'b0), 2);
    wait_drain();
    finish_test("reset");

    // One edge from queue to stage and then back-to-back words
    start_test();
    drive_word(build_word(OPCODE_AMO, AMO_FUNCT3_W, AMO_SWAP, 5'd7, 5'd8, 5'd9, 1'b0, 1'b1), 3);
    step();
    assert (id_valid_o === 1'b1) else report_mismatch("id_valid_o", 1, id_valid_o);
    repeat (4) drive_word(build_word(OPCODE_AMO, AMO_FUNCT3_W, AMO_OR, 5'($urandom),
                                     5'($urandom), 5'($urandom), 1'b0, 1'b0), 0);
    wait_drain();
    finish_test("latency");

    // Every legal code twice with random registers
    start_test();
    for (int r = 0; r < 2; r++) begin
      for (int i = 0; i < 11; i++) begin
        f5  = funct5_at(i);
        rs2 = (f5 == AMO_LR) ? 5'd0 : 5'($urandom);
        drive_word(build_word(OPCODE_AMO, AMO_FUNCT3_W, f5, 5'($urandom), 5'($urandom), rs2,
                              1'($urandom), 1'($urandom)), 0);
      end
    end
    wait_drain();
    finish_test("legal_decode");

    // Malformed atomics and foreign opcodes
    start_test();
    drive_word(build_word(OPCODE_AMO, AMO_FUNCT3_W, AMO_LR, 5'd1, 5'd2, 5'd1, 1'b0, 1'b0), 1);
    drive_word(build_word(OPCODE_AMO, AMO_FUNCT3_W, AMO_LR, 5'd3, 5'd4, 5'd31, 1'b1, 1'b1), 1);
    drive_word(build_word(OPCODE_AMO, AMO_FUNCT3_W, 5'b00101, 5'd5, 5'd6, 5'd7, 1'b0, 1'b0), 1);
    drive_word(build_word(OPCODE_AMO, AMO_FUNCT3_W, 5'b11111, 5'd8, 5'd9, 5'd10, 1'b0, 1'b0), 1);
    drive_word(build_word(OPCODE_AMO, 3'b011, AMO_ADD, 5'd1, 5'd2, 5'd3, 1'b0, 1'b0), 1);
    drive_word(build_word(OPCODE_AMO, 3'b000, AMO_SC, 5'd1, 5'd2, 5'd3, 1'b0, 1'b0), 1);
    drive_word(build_word(7'h33, AMO_FUNCT3_W, AMO_ADD, 5'd1, 5'd2, 5'd3, 1'b0, 1'b0), 1);
    drive_word(build_word(7'h03, AMO_FUNCT3_W, AMO_LR, 5'd1, 5'd2, 5'd0, 1'b0, 1'b0), 1);
    wait_drain();
    finish_test("illegal_decode");

    // Stall with one word held until the queue fills
    start_test();
    drive_word(random_word(), 0);
    while (!id_valid_o) step();
    stall_i = 1'b1;
    repeat (4) drive_word(random_word(), 0);
    assert (fetch_ready_o === 1'b0) else report_mismatch("fetch_ready_o", 0, fetch_ready_o);
    fork
      begin
        drive_word(random_word(), 0);
        drive_word(random_word(), 0);
      end
      begin
        repeat (6) step();
        stall_i = 1'b0;
      end
    join
    wait_drain();
    finish_test("back_pressure");

    // Random gaps, random stall and a mixed word stream
    start_test();
    fork
      begin
        for (int i = 0; i < T6_WORDS; i++) drive_word(random_word(), int'($urandom % 4));
        traffic_done = 1'b1;
      end
      begin
        while (!traffic_done) begin
          stall_i = ($urandom % 4) == 0;
          step();
        end
        stall_i = 1'b0;
      end
    join
    wait_drain();
    finish_test("random_traffic");

    $display("Tests passed: %0d, tests failed: %0d", tests_passed, tests_failed);
    if (tests_failed == 0 && err_cnt == 0) begin
      $display("** PASS **");
    end else begin
      $display("** FAIL **");
    end
    $finish;
  end

  // Watchdog sized from the word counts
  initial begin
    #(TIMEOUT_CYCLES * CLK_PERIOD);
    $display("Timeout after %0d cycles, words stopped coming out of the decode stage",
             TIMEOUT_CYCLES);
    $display("** FAIL **");
    $finish;
  end

endmodule : tb_amo_decode

// File: logic/amo_decode_top.sv
/*
 * AMO decode front top level
 * Fetch producer, four-entry instruction queue and RV32A decode stage
 */

module amo_decode_top import amo_pkg::*; (
  input  logic            clk,
  input  logic            rst_n_i,

  // Instruction memory port
  input  logic            fetch_valid_i,
  input  logic [XLEN-1:0] fetch_instr_i,
  output logic            fetch_ready_o,

  // Execute side
  input  logic            stall_i,
  output logic            id_valid_o,
  output logic [XLEN-1:0] id_pc_o,
  output logic            id_lsu_en_o,
  output logic            id_lsu_we_o,
  output logic            id_lsu_sext_o,
  output logic [1:0]      id_lsu_size_o,
  output logic [5:0]      id_lsu_atop_o,
  output logic            id_rf_we_o,
  output logic [1:0]      id_rf_re_o,
  output op_a_sel_e       id_op_a_sel_o,
  output op_c_sel_e       id_op_c_sel_o,
  output logic            id_illegal_o
);

  // Fetch to queue
  logic               push;
  logic [FETCH_W-1:0] push_data;
  logic               queue_full;

  // Queue to decode
  logic               pop;
  logic               queue_empty;
  logic [FETCH_W-1:0] head_data;

  //////////////////////////////////////////////////////////////////////////
  // Producer
  //////////////////////////////////////////////////////////////////////////

  instr_fetch u_instr_fetch (
    .clk           (clk),
    .rst_n_i       (rst_n_i),
    .fetch_valid_i (fetch_valid_i),
    .fetch_instr_i (fetch_instr_i),
    .fetch_ready_o (fetch_ready_o),
    .queue_full_i  (queue_full),
    .push_o        (push),
    .push_data_o   (push_data)
  );

  //////////////////////////////////////////////////////////////////////////
  // Buffer
  //////////////////////////////////////////////////////////////////////////

  instr_queue u_instr_queue (
    .clk         (clk),
    .rst_n_i     (rst_n_i),
    .push_i      (push),
    .push_data_i (push_data),
    .pop_i       (pop),
    .head_data_o (head_data),
    .full_o      (queue_full),
    .empty_o     (queue_empty)
  );

  //////////////////////////////////////////////////////////////////////////
  // Consumer
  //////////////////////////////////////////////////////////////////////////

  decode_stage u_decode_stage (
    .clk           (clk),
    .rst_n_i       (rst_n_i),
    .queue_empty_i (queue_empty),
    .head_data_i   (head_data),
    .pop_o         (pop),
    .stall_i       (stall_i),
    .id_valid_o    (id_valid_o),
    .id_pc_o       (id_pc_o),
    .id_lsu_en_o   (id_lsu_en_o),
    .id_lsu_we_o   (id_lsu_we_o),
    .id_lsu_sext_o (id_lsu_sext_o),
    .id_lsu_size_o (id_lsu_size_o),
    .id_lsu_atop_o (id_lsu_atop_o),
    .id_rf_we_o    (id_rf_we_o),
    .id_rf_re_o    (id_rf_re_o),
    .id_op_a_sel_o (id_op_a_sel_o),
    .id_op_c_sel_o (id_op_c_sel_o),
    .id_illegal_o  (id_illegal_o)
  );

endmodule : amo_decode_top

// File: logic/decode_stage.sv
/*
 * Decode stage
 * Pops the queue head whenever the ID register is free, decodes it
 * for RV32A and holds the result steady while execute stalls
 */

module decode_stage import amo_pkg::*; (
  input  logic               clk,
  input  logic               rst_n_i,

  // Queue side
  input  logic               queue_empty_i,
  input  logic [FETCH_W-1:0] head_data_i,
  output logic               pop_o,

  // Execute side
  input  logic               stall_i,
  output logic               id_valid_o,
  output logic [XLEN-1:0]    id_pc_o,
  output logic               id_lsu_en_o,
  output logic               id_lsu_we_o,
  output logic               id_lsu_sext_o,
  output logic [1:0]         id_lsu_size_o,
  output logic [5:0]         id_lsu_atop_o,
  output logic               id_rf_we_o,
  output logic [1:0]         id_rf_re_o,
  output op_a_sel_e          id_op_a_sel_o,
  output op_c_sel_e          id_op_c_sel_o,
  output logic               id_illegal_o
);

  // Decoder results for the head word
  logic            dec_lsu_en;
  logic            dec_lsu_we;
  logic            dec_lsu_sext;
  logic [1:0]      dec_lsu_size;
  logic [5:0]      dec_lsu_atop;
  logic            dec_rf_we;
  logic [1:0]      dec_rf_re;
  op_a_sel_e       dec_op_a_sel;
  op_c_sel_e       dec_op_c_sel;
  logic            dec_illegal;

  logic            id_valid_q;
  logic            stage_free;

  a_decoder u_a_decoder (
    .instr_i    (head_data_i[XLEN-1:0]),
    .lsu_en_o   (dec_lsu_en),
    .lsu_we_o   (dec_lsu_we),
    .lsu_sext_o (dec_lsu_sext),
    .lsu_size_o (dec_lsu_size),
    .lsu_atop_o (dec_lsu_atop),
    .rf_we_o    (dec_rf_we),
    .rf_re_o    (dec_rf_re),
    .op_a_sel_o (dec_op_a_sel),
    .op_c_sel_o (dec_op_c_sel),
    .illegal_o  (dec_illegal)
  );

  // Register can take a new entry when empty or when execute takes the old one
  assign stage_free = ~id_valid_q | ~stall_i;
  assign pop_o      = ~queue_empty_i & stage_free;

  // Valid flag, cleared once consumed with nothing behind it
  always_ff @(posedge clk) begin
    if (!rst_n_i) begin
      id_valid_q <= 1'b0;
    end else if (pop_o) begin
      id_valid_q <= 1'b1;
    end else if (stage_free) begin
      id_valid_q <= 1'b0;
    end
  end

  // Payload, only loaded on pop so it holds under stall
  always_ff @(posedge clk) begin
    if (pop_o) begin
      id_pc_o       <= head_data_i[FETCH_W-1 -: XLEN];
      id_lsu_en_o   <= dec_lsu_en;
      id_lsu_we_o   <= dec_lsu_we;
      id_lsu_sext_o <= dec_lsu_sext;
      id_lsu_size_o <= dec_lsu_size;
      id_lsu_atop_o <= dec_lsu_atop;
      id_rf_we_o    <= dec_rf_we;
      id_rf_re_o    <= dec_rf_re;
      id_op_a_sel_o <= dec_op_a_sel;
      id_op_c_sel_o <= dec_op_c_sel;
      id_illegal_o  <= dec_illegal;
    end
  end

  assign id_valid_o = id_valid_q;

endmodule : decode_stage

// File: logic/instr_queue.sv
/*
 * Instruction queue
 * Circular buffer of PC and word pairs with registered full and
 * empty levels; the head entry is read straight from storage
 */

module instr_queue import amo_pkg::*; (
  input  logic               clk,
  input  logic               rst_n_i,

  // Write side
  input  logic               push_i,
  input  logic [FETCH_W-1:0] push_data_i,

  // Read side
  input  logic               pop_i,
  output logic [FETCH_W-1:0] head_data_o,

  // Levels
  output logic               full_o,
  output logic               empty_o
);

  // Storage, no reset needed on payload
  logic [FETCH_W-1:0]  mem_q [QUEUE_DEPTH];

  logic [QUEUE_AW-1:0] wr_ptr_q;
  logic [QUEUE_AW-1:0] rd_ptr_q;
  logic [QUEUE_AW:0]   count_q;
  logic [QUEUE_AW:0]   count_d;
  logic                full_q;
  logic                empty_q;
  logic                push_en;
  logic                pop_en;

  // Guard against writes when full and reads when empty
  assign push_en = push_i & ~full_q;
  assign pop_en  = pop_i & ~empty_q;

  // Occupancy after this edge, simultaneous push and pop cancel
  always_comb begin
    count_d = count_q;
    if (push_en && !pop_en) begin
      count_d = count_q + 1'b1;
    end else if (pop_en && !push_en) begin
      count_d = count_q - 1'b1;
    end
  end

  // Control state
  always_ff @(posedge clk) begin
    if (!rst_n_i) begin
      wr_ptr_q <= '0;
      rd_ptr_q <= '0;
      count_q  <= '0;
      full_q   <= 1'b0;
      empty_q  <= 1'b1;
    end else begin
      if (push_en) wr_ptr_q <= wr_ptr_q + 1'b1;
      if (pop_en)  rd_ptr_q <= rd_ptr_q + 1'b1;
      count_q <= count_d;
      // Levels registered from the next count
      full_q  <= (count_d == (QUEUE_AW+1)'(QUEUE_DEPTH));
      empty_q <= (count_d == '0);
    end
  end

  // Entry write
  always_ff @(posedge clk) begin
    if (push_en) begin
      mem_q[wr_ptr_q] <= push_data_i;
    end
  end

  assign head_data_o = mem_q[rd_ptr_q];
  assign full_o      = full_q;
  assign empty_o     = empty_q;

endmodule : instr_queue

// File: logic/instr_fetch.sv
/*
 * Fetch producer
 * Accepts instruction strobes while the queue has room, tags each word
 * with its PC and advances the PC by four per accepted word
 */

module instr_fetch import amo_pkg::*; (
  input  logic               clk,
  input  logic               rst_n_i,

  // Instruction memory side
  input  logic               fetch_valid_i,
  input  logic [XLEN-1:0]    fetch_instr_i,
  output logic               fetch_ready_o,

  // Queue side
  input  logic               queue_full_i,
  output logic               push_o,
  output logic [FETCH_W-1:0] push_data_o
);

  // PC of the next word to be accepted
  logic [XLEN-1:0] pc_q;
  logic [XLEN-1:0] pc_d;
  logic            accept;

  // Only back-pressure is the queue filling up
  assign fetch_ready_o = ~queue_full_i;

  // Word taken on any edge with strobe and room
  assign accept = fetch_valid_i & fetch_ready_o;

  // No branches here, so sequential PC only
  assign pc_d = pc_q + 32'd4;

  always_ff @(posedge clk) begin
    if (!rst_n_i) begin
      pc_q <= BOOT_ADDR;
    end else if (accept) begin
      pc_q <= pc_d;
    end
  end

  // Entry goes straight to the queue in the same cycle
  assign push_o      = accept;
  assign push_data_o = {pc_q, fetch_instr_i};

endmodule : instr_fetch

// File: logic/a_decoder.sv
/*
 * RV32A decoder
 * Purely combinational; turns one instruction word into LSU and
 * register-file control fields, falling back to safe illegal defaults
 */

module a_decoder import amo_pkg::*; (
  // Raw word from the queue head
  input  logic [XLEN-1:0] instr_i,

  // LSU control
  output logic            lsu_en_o,
  output logic            lsu_we_o,
  output logic            lsu_sext_o,
  output logic [1:0]      lsu_size_o,
  output logic [5:0]      lsu_atop_o,

  // Register file and operand control
  output logic            rf_we_o,
  output logic [1:0]      rf_re_o,
  output op_a_sel_e       op_a_sel_o,
  output op_c_sel_e       op_c_sel_o,

  output logic            illegal_o
);

  // Instruction fields
  logic [6:0] opcode;
  logic [2:0] funct3;
  logic [4:0] funct5;
  logic [4:0] rs2;

  // funct5 classification
  logic       is_lr;
  logic       is_write;
  logic       legal;

  assign opcode = instr_i[6:0];
  assign funct3 = instr_i[14:12];
  assign funct5 = instr_i[31:27];
  assign rs2    = instr_i[24:20];

  // Sort funct5 into LR, writing ops (SC plus RMW), or unused
  always_comb begin
    is_lr    = 1'b0;
    is_write = 1'b0;
    unique case (funct5)
      AMO_LR: is_lr = 1'b1;
      AMO_SC, AMO_SWAP, AMO_ADD, AMO_XOR, AMO_AND,
      AMO_OR, AMO_MIN, AMO_MAX, AMO_MINU, AMO_MAXU: is_write = 1'b1;
      default: begin
        // Unused code, stays illegal
        is_lr    = 1'b0;
        is_write = 1'b0;
      end
    endcase
  end

  // LR must have rs2 zero, anything else with a known code is fine
  assign legal = (opcode == OPCODE_AMO) && (funct3 == AMO_FUNCT3_W) &&
                 (is_write || (is_lr && (rs2 == 5'd0)));

  always_comb begin
    // Illegal defaults
    lsu_en_o   = 1'b0;
    lsu_we_o   = 1'b0;
    lsu_sext_o = 1'b0;
    lsu_size_o = LSU_SIZE_WORD;
    lsu_atop_o = 6'd0;
    rf_we_o    = 1'b0;
    rf_re_o    = 2'b00;
    op_a_sel_o = OP_A_NONE;
    op_c_sel_o = OP_C_NONE;
    illegal_o  = 1'b1;

    if (legal) begin
      // Common to every word AMO
      illegal_o  = 1'b0;
      lsu_en_o   = 1'b1;
      lsu_sext_o = 1'b1;
      rf_we_o    = 1'b1;
      rf_re_o[0] = 1'b1;
      op_a_sel_o = OP_A_REGA_OR_FWD;
      lsu_size_o = LSU_SIZE_WORD;
      lsu_atop_o = {1'b1, funct5};

      // SC and RMW read rs2 as write data, LR leaves it alone
      if (is_write) begin
        lsu_we_o   = 1'b1;
        rf_re_o[1] = 1'b1;
        op_c_sel_o = OP_C_REGB_OR_FWD;
      end
    end
  end

endmodule : a_decoder

// File: logic/amo_pkg.sv
/*
 * AMO decode front, shared definitions
 * Widths, boot address, queue sizing, RV32A opcode and funct5 codes,
 * operand select encodings and the LSU size code
 */

package amo_pkg;

  //////////////////////////////////////////////////////////////////////////
  // Datapath and fetch sizing
  //////////////////////////////////////////////////////////////////////////

  // Instruction word and PC width
  localparam int unsigned XLEN = 32;

  // First fetch address out of reset
  localparam logic [XLEN-1:0] BOOT_ADDR = 32'h0000_0080;

  // Queue entry is PC in the upper half, instruction word in the lower half
  localparam int unsigned FETCH_W = 2 * XLEN;

  // Queue sizing, pointers wrap naturally at the depth
  localparam int unsigned QUEUE_DEPTH = 4;
  localparam int unsigned QUEUE_AW    = 2;

  //////////////////////////////////////////////////////////////////////////
  // RV32A encodings
  //////////////////////////////////////////////////////////////////////////

  // Major opcode for atomics
  localparam logic [6:0] OPCODE_AMO = 7'h2f;

  // funct3 for word sized atomics, the only width on RV32
  localparam logic [2:0] AMO_FUNCT3_W = 3'b010;

  // funct5 codes in instr[31:27]
  localparam logic [4:0] AMO_LR   = 5'b00010;
  localparam logic [4:0] AMO_SC   = 5'b00011;
  localparam logic [4:0] AMO_SWAP = 5'b00001;
  localparam logic [4:0] AMO_ADD  = 5'b00000;
  localparam logic [4:0] AMO_XOR  = 5'b00100;
  localparam logic [4:0] AMO_AND  = 5'b01100;
  localparam logic [4:0] AMO_OR   = 5'b01000;
  localparam logic [4:0] AMO_MIN  = 5'b10000;
  localparam logic [4:0] AMO_MAX  = 5'b10100;
  localparam logic [4:0] AMO_MINU = 5'b11000;
  localparam logic [4:0] AMO_MAXU = 5'b11100;

  //////////////////////////////////////////////////////////////////////////
  // Operand selects and LSU size
  //////////////////////////////////////////////////////////////////////////

  // Operand A source, rs1 carries the address for every AMO
  typedef enum logic [1:0] {
    OP_A_REGA_OR_FWD = 2'b00,
    OP_A_NONE        = 2'b11
  } op_a_sel_e;

  // Operand C source, rs2 carries the store data for SC and RMW ops
  typedef enum logic [1:0] {
    OP_C_REGB_OR_FWD = 2'b01,
    OP_C_NONE        = 2'b11
  } op_c_sel_e;

  // LSU transfer size code as seen by the load/store unit
  // 2'b00 selects a 32-bit word
  localparam logic [1:0] LSU_SIZE_WORD = 2'b00;

endpackage : amo_pkg
